/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_bmu_decode
FILELIST = verilog.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* design/bmu_decode_if.sv */
`timescale 1ns/1ns
`default_nettype none

// One decoder result, combinational on the current instruction.
interface bmu_decode_if;
    import bmu_uop_pkg::*;

    bmu_decode_t result;

    modport decoder (
        output result
    );

    modport stage (
        input result
    );

endinterface

`default_nettype wire

/* design/bmu_decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bmu_defines.svh"

module bmu_decode_stage (
    input  logic                   clk_i,
    input  logic                   reset_i,

    input  logic                   instr_valid_i,
    input  riscv_isa_pkg::instr_t  instr_i,

    output logic                   unit_valid_o,
    output logic                   exception_o,
    output bmu_uop_pkg::bmu_uop_t  uop_o,
    output logic [`BMU_REG_W-1:0]  rs1_o,
    output logic [`BMU_REG_W-1:0]  rs2_o,
    output logic [`BMU_REG_W-1:0]  rd_o,
    output logic                   use_rs2_o,
    output logic                   imm_valid_o,
    output logic [`BMU_XLEN-1:0]   immediate_o
);
    import riscv_isa_pkg::*;
    import bmu_uop_pkg::*;

    bmu_decode_if imm_if ();
    bmu_decode_if reg_if ();

    bmu_imm_decoder u_imm_decoder (
        .instr_i (instr_i),
        .dec     (imm_if.decoder)
    );

    bmu_reg_decoder u_reg_decoder (
        .instr_i (instr_i),
        .dec     (reg_if.decoder)
    );

    bmu_decode_t sel;
    bmu_decode_t dec_q;

    always_comb begin
        case (instr_i.major)
            OP_IMM:  sel = imm_if.result;
            OP:      sel = reg_if.result;
            default: sel = illegal_decode();
        endcase

        // Compressed encodings never reach this unit.
        if (instr_i[`BMU_QUAD_HI:`BMU_QUAD_LO] != `BMU_QUAD_32) begin
            sel = illegal_decode();
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            dec_q <= '0;
        end else if (instr_valid_i) begin
            dec_q <= sel;
        end else begin
            dec_q.valid   <= 1'b0; // Payload holds, flags drop.
            dec_q.illegal <= 1'b0;
        end
    end

    assign unit_valid_o = dec_q.valid;
    assign exception_o  = dec_q.illegal;
    assign uop_o        = dec_q.uop;
    assign rs1_o        = dec_q.rs1;
    assign rs2_o        = dec_q.rs2;
    assign rd_o         = dec_q.rd;
    assign use_rs2_o    = dec_q.use_rs2;
    assign imm_valid_o  = dec_q.imm_valid;
    assign immediate_o  = dec_q.immediate;

    // Both decoders and the major/quadrant check must agree on exclusivity.
    a_valid_xor_exc: assert property (
        @(posedge clk_i) disable iff (reset_i) !(unit_valid_o && exception_o)
    ) else $error("unit_valid_o and exception_o high together");

endmodule

`default_nettype wire

/* design/bmu_defines.svh */
`ifndef BMU_DEFINES_SVH
`define BMU_DEFINES_SVH

// Data word and register file geometry.
`define BMU_XLEN     32
`define BMU_REG_W    5
`define BMU_SHAMT_W  5

// Instruction field widths.
`define BMU_FUNCT7_W 7
`define BMU_FUNCT3_W 3
`define BMU_MAJOR_W  5

// Fixed bit positions inside the 32-bit instruction word.
`define BMU_IMM12_HI 31
`define BMU_IMM12_LO 20
`define BMU_QUAD_HI  1
`define BMU_QUAD_LO  0

// Quadrant value of every uncompressed instruction.
`define BMU_QUAD_32  2'b11

`endif

/* design/bmu_imm_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bmu_defines.svh"

module bmu_imm_decoder (
    input riscv_isa_pkg::instr_t instr_i,
    bmu_decode_if.decoder        dec
);
    import riscv_isa_pkg::*;
    import bmu_uop_pkg::*;

    bmu_decode_t res;
    logic        illegal;
    logic        shamt_op; // Shift amount sits in the rs2 field.
    logic [`BMU_IMM12_HI-`BMU_IMM12_LO:0] imm12;

    assign imm12 = instr_i[`BMU_IMM12_HI:`BMU_IMM12_LO];

    always_comb begin
        res      = '0;
        illegal  = 1'b0;
        shamt_op = 1'b0;

        case (instr_i.funct3)
            F3_BSET: begin
                case (instr_i.funct7)
                    F7_BSET: begin
                        res      = build_uop(LOGICOP, BSET, instr_i.rs1, instr_i.rd);
                        shamt_op = 1'b1;
                    end
                    F7_BCLR: begin
                        res      = build_uop(LOGICOP, BCLR, instr_i.rs1, instr_i.rd);
                        shamt_op = 1'b1;
                    end
                    F7_BINV: begin
                        res      = build_uop(LOGICOP, BINV, instr_i.rs1, instr_i.rd);
                        shamt_op = 1'b1;
                    end
                    F7_ROT: begin
                        // The rs2 field picks the unary operation.
                        case (instr_i.rs2)
                            SEL_CLZ:   res = build_uop(COUNT, CLZ, instr_i.rs1, instr_i.rd);
                            SEL_CTZ:   res = build_uop(COUNT, CTZ, instr_i.rs1, instr_i.rd);
                            SEL_CPOP:  res = build_uop(COUNT, CPOP, instr_i.rs1, instr_i.rd);
                            SEL_SEXTB: res = build_uop(EXTEND, SEXTB, instr_i.rs1, instr_i.rd);
                            SEL_SEXTH: res = build_uop(EXTEND, SEXTH, instr_i.rs1, instr_i.rd);
                            default:   illegal = 1'b1;
                        endcase
                    end
                    default: illegal = 1'b1;
                endcase
            end

            F3_BEXT: begin
                case (instr_i.funct7)
                    F7_BCLR: begin
                        res      = build_uop(LOGICOP, BEXT, instr_i.rs1, instr_i.rd);
                        shamt_op = 1'b1;
                    end
                    F7_ROT: begin
                        res      = build_uop(ROTATE, ROR, instr_i.rs1, instr_i.rd);
                        shamt_op = 1'b1;
                    end
                    F7_BINV: begin
                        if (imm12 == IMM_REV8) begin
                            res = build_uop(BYTEOP, REV8, instr_i.rs1, instr_i.rd);
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                    F7_BSET: begin
                        if (imm12 == IMM_ORCB) begin
                            res = build_uop(BYTEOP, ORCB, instr_i.rs1, instr_i.rd);
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                    default: illegal = 1'b1;
                endcase
            end

            default: illegal = 1'b1; // Base ALU immediates live elsewhere.
        endcase

        if (shamt_op) begin
            res.immediate = shamt_imm(instr_i);
            res.imm_valid = 1'b1;
        end
    end

    assign dec.result = illegal ? illegal_decode() : res;

    // An immediate is only ever offered with a recognized operation.
    a_imm_legal: assert final (!(res.imm_valid && illegal))
        else $error("imm decoder flagged an immediate on an illegal instruction");

endmodule

`default_nettype wire

/* design/bmu_reg_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "bmu_defines.svh"

module bmu_reg_decoder (
    input riscv_isa_pkg::instr_t instr_i,
    bmu_decode_if.decoder        dec
);
    import riscv_isa_pkg::*;
    import bmu_uop_pkg::*;

    bmu_decode_t res;
    logic        illegal;
    logic        unary; // Single-source form, rs2 is not read.

    always_comb begin
        res     = '0;
        illegal = 1'b0;
        unary   = 1'b0;

        case (instr_i.funct3)
            F3_BSET: begin
                case (instr_i.funct7)
                    F7_BSET: res = build_uop(LOGICOP, BSET, instr_i.rs1, instr_i.rd);
                    F7_BCLR: res = build_uop(LOGICOP, BCLR, instr_i.rs1, instr_i.rd);
                    F7_BINV: res = build_uop(LOGICOP, BINV, instr_i.rs1, instr_i.rd);
                    F7_ROT:  res = build_uop(ROTATE, ROL, instr_i.rs1, instr_i.rd);
                    default: illegal = 1'b1;
                endcase
            end

            F3_SH1ADD: begin
                if (instr_i.funct7 == F7_SHADD) begin
                    res = build_uop(SHADD, SH1ADD, instr_i.rs1, instr_i.rd);
                end else begin
                    illegal = 1'b1;
                end
            end

            F3_XNOR: begin
                case (instr_i.funct7)
                    F7_SHADD:  res = build_uop(SHADD, SH2ADD, instr_i.rs1, instr_i.rd);
                    F7_MINMAX: res = build_uop(COMPARE, MIN, instr_i.rs1, instr_i.rd);
                    F7_NEG:    res = build_uop(LOGICOP, XNOR, instr_i.rs1, instr_i.rd);
                    F7_ZEXT: begin
                        if (instr_i.rs2 == '0) begin
                            res   = build_uop(EXTEND, ZEXTH, instr_i.rs1, instr_i.rd);
                            unary = 1'b1;
                        end else begin
                            illegal = 1'b1; // PACK is not part of this unit.
                        end
                    end
                    default: illegal = 1'b1;
                endcase
            end

            F3_BEXT: begin
                case (instr_i.funct7)
                    F7_MINMAX: res = build_uop(COMPARE, MINU, instr_i.rs1, instr_i.rd);
                    F7_BCLR:   res = build_uop(LOGICOP, BEXT, instr_i.rs1, instr_i.rd);
                    F7_ROT:    res = build_uop(ROTATE, ROR, instr_i.rs1, instr_i.rd);
                    default:   illegal = 1'b1;
                endcase
            end

            F3_ORN: begin
                case (instr_i.funct7)
                    F7_SHADD:  res = build_uop(SHADD, SH3ADD, instr_i.rs1, instr_i.rd);
                    F7_MINMAX: res = build_uop(COMPARE, MAX, instr_i.rs1, instr_i.rd);
                    F7_NEG:    res = build_uop(LOGICOP, ORN, instr_i.rs1, instr_i.rd);
                    default:   illegal = 1'b1;
                endcase
            end

            F3_ANDN: begin
                case (instr_i.funct7)
                    F7_NEG:    res = build_uop(LOGICOP, ANDN, instr_i.rs1, instr_i.rd);
                    F7_MINMAX: res = build_uop(COMPARE, MAXU, instr_i.rs1, instr_i.rd);
                    default:   illegal = 1'b1;
                endcase
            end

            default: illegal = 1'b1;
        endcase

        if (!unary) begin
            res.rs2     = instr_i.rs2;
            res.use_rs2 = 1'b1;
        end
    end

    assign dec.result = illegal ? illegal_decode() : res;

    // Register forms never carry an immediate to the stage.
    a_reg_no_imm: assert final (!dec.result.imm_valid)
        else $error("reg decoder offered an immediate");

endmodule

`default_nettype wire

/* design/bmu_uop_pkg.sv */
`default_nettype none

`include "bmu_defines.svh"

package bmu_uop_pkg;

    typedef enum logic [2:0] {
        LOGICOP,
        COUNT,
        EXTEND,
        ROTATE,
        BYTEOP,
        SHADD,
        COMPARE
    } bmu_class_t;

    typedef enum logic [4:0] {
        BSET, BCLR, BINV, BEXT,
        ANDN, ORN, XNOR,
        CLZ, CTZ, CPOP,
        SEXTB, SEXTH, ZEXTH,
        ROL, ROR,
        REV8, ORCB,
        SH1ADD, SH2ADD, SH3ADD,
        MIN, MINU, MAX, MAXU
    } bmu_opcode_t;

    typedef struct packed {
        bmu_class_t  op_class;
        bmu_opcode_t opcode;
    } bmu_uop_t;

    typedef struct packed {
        logic                  valid;
        bmu_uop_t              uop;
        logic                  illegal;
        logic [`BMU_REG_W-1:0] rs1;
        logic [`BMU_REG_W-1:0] rs2;
        logic [`BMU_REG_W-1:0] rd;
        logic                  use_rs2;
        logic [`BMU_XLEN-1:0]  immediate;
        logic                  imm_valid;
    } bmu_decode_t;

    // Recognized operation with its rs1 and rd; rs2 and immediate start cleared.
    function automatic bmu_decode_t build_uop(
        input bmu_class_t            op_class,
        input bmu_opcode_t           opcode,
        input logic [`BMU_REG_W-1:0] rs1,
        input logic [`BMU_REG_W-1:0] rd
    );
        bmu_decode_t d;
        d              = '0;
        d.valid        = 1'b1;
        d.uop.op_class = op_class;
        d.uop.opcode   = opcode;
        d.rs1          = rs1;
        d.rd           = rd;
        return d;
    endfunction

    function automatic bmu_decode_t illegal_decode();
        bmu_decode_t d;
        d         = '0;
        d.illegal = 1'b1;
        return d;
    endfunction

endpackage

`default_nettype wire

/* design/riscv_isa_pkg.sv */
`default_nettype none

`include "bmu_defines.svh"

package riscv_isa_pkg;

    // R-type view; I-type shifts keep shamt in rs2.
    typedef struct packed {
        logic [`BMU_FUNCT7_W-1:0] funct7;
        logic [`BMU_REG_W-1:0]    rs2;
        logic [`BMU_REG_W-1:0]    rs1;
        logic [`BMU_FUNCT3_W-1:0] funct3;
        logic [`BMU_REG_W-1:0]    rd;
        logic [`BMU_MAJOR_W-1:0]  major;
        logic [1:0]               quadrant;
    } instr_t;

    typedef enum logic [`BMU_MAJOR_W-1:0] {
        OP_IMM = 5'b00100,
        OP     = 5'b01100
    } major_op_t;

    // One value per funct3, named after the first user.
    typedef enum logic [`BMU_FUNCT3_W-1:0] {
        F3_BSET   = 3'b001, // Also BCLR, BINV, ROL and the unary group.
        F3_SH1ADD = 3'b010,
        F3_XNOR   = 3'b100, // Also SH2ADD, MIN and ZEXTH.
        F3_BEXT   = 3'b101, // Also ROR, MINU, REV8 and ORCB.
        F3_ORN    = 3'b110, // Also SH3ADD and MAX.
        F3_ANDN   = 3'b111  // Also MAXU.
    } funct3_t;

    typedef enum logic [`BMU_FUNCT7_W-1:0] {
        F7_ZEXT   = 7'b0000100,
        F7_MINMAX = 7'b0000101,
        F7_SHADD  = 7'b0010000,
        F7_BSET   = 7'b0010100, // Also ORCB.
        F7_NEG    = 7'b0100000, // ANDN, ORN, XNOR.
        F7_BCLR   = 7'b0100100, // Also BEXT.
        F7_ROT    = 7'b0110000, // Also the unary count and sign-extend group.
        F7_BINV   = 7'b0110100  // Also REV8.
    } funct7_t;

    // Unary selector carried in the rs2 field.
    typedef enum logic [`BMU_REG_W-1:0] {
        SEL_CLZ   = 5'd0,
        SEL_CTZ   = 5'd1,
        SEL_CPOP  = 5'd2,
        SEL_SEXTB = 5'd4,
        SEL_SEXTH = 5'd5
    } unary_sel_t;

    localparam logic [11:0] IMM_REV8 = 12'b011010011000;
    localparam logic [11:0] IMM_ORCB = 12'b001010000111;

    function automatic logic [`BMU_XLEN-1:0] shamt_imm(input instr_t instr);
        return {{(`BMU_XLEN - `BMU_SHAMT_W){1'b0}}, instr.rs2[`BMU_SHAMT_W-1:0]};
    endfunction

endpackage

`default_nettype wire

/* test/bmu_decode_tasks.svh */
function automatic logic [31:0] encode(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] major);
    return {f7, rs2, rs1, f3, rd, major, 2'b11}; // Uncompressed quadrant.
endfunction

function automatic logic [4:0] rand_reg();
    logic [31:0] r;
    r = $random(seed);
    return r[4:0];
endfunction

task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
endtask

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
        abort_run($sformatf("FAILED %s: expected 0x%0h, actual 0x%0h",
                            name, expected, actual));
    end
endtask

// Drives one valid cycle and waits for either flag to rise.
task automatic decode_one(input string tname, input logic [31:0] word);
    int waited;
    @(posedge clk_i);
    instr_valid_i <= 1'b1;
    instr_i       <= word;
    @(posedge clk_i);
    instr_valid_i <= 1'b0;
    waited = 0;
    @(negedge clk_i);
    while (!(unit_valid_o || exception_o)) begin
        waited++;
        if (waited > WAIT_LIMIT) begin
            abort_run($sformatf("%s: the DUT gave no decode result in time", tname));
        end
        @(negedge clk_i);
    end
    check_value({tname, " latency"}, 32'd0, 32'(waited)); // Result right after capture.
endtask

task automatic check_decode(input string tname, input bmu_class_t cls, input bmu_opcode_t opc,
                            input logic [4:0] rs1, input logic [4:0] rs2, input logic [4:0] rd,
                            input logic use_rs2, input logic imm_valid,
                            input logic [31:0] imm);
    check_value({tname, " valid"}, 32'd1, 32'(unit_valid_o));
    check_value({tname, " exception"}, 32'd0, 32'(exception_o));
    check_value({tname, " class"}, 32'(cls), 32'(uop_o.op_class));
    check_value({tname, " opcode"}, 32'(opc), 32'(uop_o.opcode));
    check_value({tname, " rs1"}, 32'(rs1), 32'(rs1_o));
    check_value({tname, " rs2"}, 32'(rs2), 32'(rs2_o));
    check_value({tname, " rd"}, 32'(rd), 32'(rd_o));
    check_value({tname, " use_rs2"}, 32'(use_rs2), 32'(use_rs2_o));
    check_value({tname, " imm_valid"}, 32'(imm_valid), 32'(imm_valid_o));
    check_value({tname, " immediate"}, imm, immediate_o);
endtask

task automatic check_illegal(input string tname, input logic [31:0] word);
    decode_one(tname, word);
    check_value({tname, " exception"}, 32'd1, 32'(exception_o));
    check_value({tname, " valid"}, 32'd0, 32'(unit_valid_o));
    check_value({tname, " uop"}, 32'd0, 32'(uop_o));
endtask

/* test/tb_bmu_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_bmu_decode;
    import riscv_isa_pkg::*;
    import bmu_uop_pkg::*;

    localparam logic [4:0] MAJ_OP_IMM = 5'b00100;
    localparam logic [4:0] MAJ_OP     = 5'b01100;
    localparam logic [4:0] MAJ_STORE  = 5'b01000;
    localparam int         WAIT_LIMIT = 8;

    logic        clk_i = 1'b0;
    logic        reset_i;
    logic        instr_valid_i;
    instr_t      instr_i;
    logic        unit_valid_o;
    logic        exception_o;
    bmu_uop_t    uop_o;
    logic [4:0]  rs1_o, rs2_o, rd_o;
    logic        use_rs2_o;
    logic        imm_valid_o;
    logic [31:0] immediate_o;
    integer      seed;

    bmu_decode_stage dut_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .unit_valid_o  (unit_valid_o),
        .exception_o   (exception_o),
        .uop_o         (uop_o),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .rd_o          (rd_o),
        .use_rs2_o     (use_rs2_o),
        .imm_valid_o   (imm_valid_o),
        .immediate_o   (immediate_o)
    );

    always #10 clk_i = ~clk_i;

    `include "bmu_decode_tasks.svh"

    // Shift amount rides in the rs2 field and comes back as the immediate.
    task automatic run_imm(input string tname, input logic [6:0] f7, input logic [2:0] f3,
                           input bmu_class_t cls, input bmu_opcode_t opc);
        logic [4:0] rs1, rd, shamt;
        rs1   = rand_reg();
        rd    = rand_reg();
        shamt = rand_reg();
        decode_one(tname, encode(f7, shamt, rs1, f3, rd, MAJ_OP_IMM));
        check_decode(tname, cls, opc, rs1, 5'd0, rd, 1'b0, 1'b1, {27'd0, shamt});
    endtask

    task automatic run_unary(input string tname, input logic [11:0] imm12,
                             input logic [2:0] f3, input logic [4:0] major,
                             input bmu_class_t cls, input bmu_opcode_t opc);
        logic [4:0] rs1, rd;
        rs1 = rand_reg();
        rd  = rand_reg();
        decode_one(tname, encode(imm12[11:5], imm12[4:0], rs1, f3, rd, major));
        check_decode(tname, cls, opc, rs1, 5'd0, rd, 1'b0, 1'b0, 32'd0);
    endtask

    task automatic run_reg(input string tname, input logic [6:0] f7, input logic [2:0] f3,
                           input bmu_class_t cls, input bmu_opcode_t opc);
        logic [4:0] rs1, rs2, rd;
        rs1 = rand_reg();
        rs2 = rand_reg();
        rd  = rand_reg();
        decode_one(tname, encode(f7, rs2, rs1, f3, rd, MAJ_OP));
        check_decode(tname, cls, opc, rs1, rs2, rd, 1'b1, 1'b0, 32'd0);
    endtask

    // Alternates ANDN and BINVI at random, one new word per clock.
    task automatic test_streaming();
        logic [4:0]  rs1[20];
        logic [4:0]  rs2[20];
        logic [4:0]  rd[20];
        logic        is_reg[20];
        logic [31:0] r;
        string       tname;
        for (int i = 0; i <= 20; i++) begin
            @(posedge clk_i);
            if (i < 20) begin
                r         = $random(seed);
                rs1[i]    = r[4:0];
                rs2[i]    = r[9:5];
                rd[i]     = r[14:10];
                is_reg[i] = r[15];
                instr_valid_i <= 1'b1;
                instr_i <= is_reg[i] ? encode(7'b0100000, rs2[i], rs1[i], 3'b111, rd[i], MAJ_OP)
                                     : encode(7'b0110100, rs2[i], rs1[i], 3'b001, rd[i],
                                              MAJ_OP_IMM);
            end else begin
                instr_valid_i <= 1'b0;
            end
            @(negedge clk_i);
            if (i > 0) begin
                tname = $sformatf("stream %0d", i - 1);
                if (is_reg[i-1]) begin
                    check_decode(tname, LOGICOP, ANDN, rs1[i-1], rs2[i-1], rd[i-1],
                                 1'b1, 1'b0, 32'd0);
                end else begin
                    check_decode(tname, LOGICOP, BINV, rs1[i-1], 5'd0, rd[i-1],
                                 1'b0, 1'b1, {27'd0, rs2[i-1]});
                end
            end
        end
        @(posedge clk_i);
        @(negedge clk_i);
        check_value("stream idle valid", 32'd0, 32'(unit_valid_o));
        check_value("stream idle exception", 32'd0, 32'(exception_o));
    endtask

    initial begin
        seed          = 32'hb7170590;
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        check_value("reset valid", 32'd0, 32'(unit_valid_o));
        check_value("reset exception", 32'd0, 32'(exception_o));
        check_value("reset immediate", 32'd0, immediate_o);

        run_imm("bseti", 7'b0010100, 3'b001, LOGICOP, BSET);
        run_imm("bclri", 7'b0100100, 3'b001, LOGICOP, BCLR);
        run_imm("binvi", 7'b0110100, 3'b001, LOGICOP, BINV);
        run_imm("bexti", 7'b0100100, 3'b101, LOGICOP, BEXT);
        run_imm("rori", 7'b0110000, 3'b101, ROTATE, ROR);

        run_unary("clz", 12'b011000000000, 3'b001, MAJ_OP_IMM, COUNT, CLZ);
        run_unary("ctz", 12'b011000000001, 3'b001, MAJ_OP_IMM, COUNT, CTZ);
        run_unary("cpop", 12'b011000000010, 3'b001, MAJ_OP_IMM, COUNT, CPOP);
        run_unary("sext.b", 12'b011000000100, 3'b001, MAJ_OP_IMM, EXTEND, SEXTB);
        run_unary("sext.h", 12'b011000000101, 3'b001, MAJ_OP_IMM, EXTEND, SEXTH);
        run_unary("rev8", 12'b011010011000, 3'b101, MAJ_OP_IMM, BYTEOP, REV8);
        run_unary("orc.b", 12'b001010000111, 3'b101, MAJ_OP_IMM, BYTEOP, ORCB);
        run_unary("zext.h", 12'b000010000000, 3'b100, MAJ_OP, EXTEND, ZEXTH);

        run_reg("bset", 7'b0010100, 3'b001, LOGICOP, BSET);
        run_reg("bclr", 7'b0100100, 3'b001, LOGICOP, BCLR);
        run_reg("binv", 7'b0110100, 3'b001, LOGICOP, BINV);
        run_reg("bext", 7'b0100100, 3'b101, LOGICOP, BEXT);
        run_reg("rol", 7'b0110000, 3'b001, ROTATE, ROL);
        run_reg("ror", 7'b0110000, 3'b101, ROTATE, ROR);
        run_reg("andn", 7'b0100000, 3'b111, LOGICOP, ANDN);
        run_reg("orn", 7'b0100000, 3'b110, LOGICOP, ORN);
        run_reg("xnor", 7'b0100000, 3'b100, LOGICOP, XNOR);
        run_reg("sh1add", 7'b0010000, 3'b010, SHADD, SH1ADD);
        run_reg("sh2add", 7'b0010000, 3'b100, SHADD, SH2ADD);
        run_reg("sh3add", 7'b0010000, 3'b110, SHADD, SH3ADD);
        run_reg("min", 7'b0000101, 3'b100, COMPARE, MIN);
        run_reg("minu", 7'b0000101, 3'b101, COMPARE, MINU);
        run_reg("max", 7'b0000101, 3'b110, COMPARE, MAX);
        run_reg("maxu", 7'b0000101, 3'b111, COMPARE, MAXU);

        check_illegal("bad funct7", encode(7'b0100001, 5'd3, 5'd4, 3'b111, 5'd5, MAJ_OP));
        check_illegal("bad count sel", encode(7'b0110000, 5'd3, 5'd4, 3'b001, 5'd5, MAJ_OP_IMM));
        check_illegal("bad rev8", encode(7'b0110100, 5'b11001, 5'd4, 3'b101, 5'd5, MAJ_OP_IMM));
        check_illegal("bad major", encode(7'b0100000, 5'd3, 5'd4, 3'b111, 5'd5, MAJ_STORE));
        check_illegal("bad quadrant",
                      {encode(7'b0100000, 5'd3, 5'd4, 3'b111, 5'd5, MAJ_OP)} & ~32'd1);

        test_streaming();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+design
+incdir+test
design/riscv_isa_pkg.sv
design/bmu_uop_pkg.sv
design/bmu_decode_if.sv
design/bmu_imm_decoder.sv
design/bmu_reg_decoder.sv
design/bmu_decode_stage.sv
test/tb_bmu_decode.sv
